// File: build.f
+incdir+include
design/aq_bus_pkg.sv
design/aq_periph_pkg.sv
design/aq_io_decode.sv
design/aq_machine_timer.sv
design/aq_video_regs.sv
design/aq_audio_mixer.sv
design/aq_io_top.sv
test/tb_clock_gen.sv
test/tb_aq_io_top.sv

// File: design/aq_audio_mixer.sv
`default_nettype none

module aq_audio_mixer import aq_periph_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire stereo_t pcm,
    input  wire stereo_t fm,
    output stereo_t      mix
);

    // Sum at 17 bits, then clamp to the 16-bit range
    function automatic sample_t sat_add(sample_t a, sample_t b);
        logic [16:0] sum;
        sum = {a[15], a} + {b[15], b};
        case (sum[16:15])
            2'b01:   return 16'sh7FFF;
            2'b10:   return 16'sh8000;
            default: return sample_t'(sum[15:0]);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mix <= '0;
        end else begin
            mix.left  <= sat_add(pcm.left, fm.left);
            mix.right <= sat_add(pcm.right, fm.right);
        end
    end

    // Output stays known once out of reset
    a_mix_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mix))
        else $error("aq_audio_mixer: mix has X or Z");

endmodule

`default_nettype wire

// File: design/aq_bus_pkg.sv
`default_nettype none

package aq_bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_bytesel_t;

    // One access from the CPU side, valid for a single cycle
    typedef struct packed {
        logic         strobe;
        logic         wren;
        bus_addr_t    addr;
        bus_data_t    wrdata;
        bus_bytesel_t bytesel;
    } bus_req_t;

    // Per-register write enables from the decoder
    typedef struct packed {
        logic vctrl;
        logic virqline;
        logic l1_scrx;
        logic l1_scry;
        logic l2_scrx;
        logic l2_scry;
        logic mtime;
        logic mtimeh;
        logic mtimecmp;
        logic mtimecmph;
    } reg_wen_t;

endpackage

`default_nettype wire

// File: design/aq_io_decode.sv
`default_nettype none

`include "aq_cfg.svh"

module aq_io_decode import aq_bus_pkg::*, aq_periph_pkg::*; (
    input  wire bus_req_t    bus,
    output reg_wen_t         wen,
    input  wire mtime_t      mtime,
    input  wire mtime_t      mtimecmp,
    input  wire video_regs_t video_regs,
    output bus_data_t        rddata
);

    bus_addr_t word_addr;
    reg_wen_t  hit;

    // Registers are whole words, so the byte offset and byte selects play no part
    assign word_addr = {bus.addr[31:2], 2'b00};

    ////////////////////////////////////////////////////////////////////////
    // Address match and write enables
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        hit           = '0;
        hit.vctrl     = (word_addr == `AQ_ADDR_VCTRL);
        hit.virqline  = (word_addr == `AQ_ADDR_VIRQLINE);
        hit.l1_scrx   = (word_addr == `AQ_ADDR_L1_SCRX);
        hit.l1_scry   = (word_addr == `AQ_ADDR_L1_SCRY);
        hit.l2_scrx   = (word_addr == `AQ_ADDR_L2_SCRX);
        hit.l2_scry   = (word_addr == `AQ_ADDR_L2_SCRY);
        hit.mtime     = (word_addr == `AQ_ADDR_MTIME);
        hit.mtimeh    = (word_addr == `AQ_ADDR_MTIMEH);
        hit.mtimecmp  = (word_addr == `AQ_ADDR_MTIMECMP);
        hit.mtimecmph = (word_addr == `AQ_ADDR_MTIMECMPH);
    end

    assign wen = (bus.strobe && bus.wren) ? hit : '0;

    ////////////////////////////////////////////////////////////////////////
    // Read-back multiplexer
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        rddata = '0;
        if (bus.strobe) begin
            case (word_addr)
                `AQ_ADDR_VCTRL:     rddata = bus_data_t'(video_regs.vctrl);
                `AQ_ADDR_VIRQLINE:  rddata = bus_data_t'(video_regs.irqline);
                `AQ_ADDR_L1_SCRX:   rddata = bus_data_t'(video_regs.l1_scrx);
                `AQ_ADDR_L1_SCRY:   rddata = bus_data_t'(video_regs.l1_scry);
                `AQ_ADDR_L2_SCRX:   rddata = bus_data_t'(video_regs.l2_scrx);
                `AQ_ADDR_L2_SCRY:   rddata = bus_data_t'(video_regs.l2_scry);
                `AQ_ADDR_MTIME:     rddata = mtime[31:0];
                `AQ_ADDR_MTIMEH:    rddata = mtime[63:32];
                `AQ_ADDR_MTIMECMP:  rddata = mtimecmp[31:0];
                `AQ_ADDR_MTIMECMPH: rddata = mtimecmp[63:32];
                // Unmapped words read as zero
                default:            rddata = '0;
            endcase
        end
    end

    // Two registers must never be written by one access
    always_comb begin
        assert ($onehot0(wen))
        else $error("aq_io_decode: more than one write enable at %h", word_addr);
    end

endmodule

`default_nettype wire

// File: design/aq_io_top.sv
`default_nettype none

`include "aq_cfg.svh"

module aq_io_top import aq_bus_pkg::*, aq_periph_pkg::*; #(
    parameter int tick_div = `AQ_TICK_DIV_DEFAULT
) (
    input  wire              clk,
    input  wire              reset,
    input  wire bus_req_t    bus,
    output wire bus_data_t   rddata,
    input  wire stereo_t     pcm,
    input  wire stereo_t     fm,
    output wire stereo_t     mix,
    output wire video_regs_t video_regs,
    output wire              timer_irq
);

    reg_wen_t wen;
    mtime_t   mtime;
    mtime_t   mtimecmp;

    ////////////////////////////////////////////////////////////////////////
    // Register bus
    ////////////////////////////////////////////////////////////////////////
    aq_io_decode i_aq_io_decode (
        .bus        (bus),
        .wen        (wen),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .video_regs (video_regs),
        .rddata     (rddata)
    );

    aq_machine_timer #(
        .tick_div (tick_div)
    ) i_aq_machine_timer (
        .clk       (clk),
        .reset     (reset),
        .wen       (wen),
        .wrdata    (bus.wrdata),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

    aq_video_regs i_aq_video_regs (
        .clk    (clk),
        .reset  (reset),
        .wen    (wen),
        .wrdata (bus.wrdata),
        .regs   (video_regs)
    );

    ////////////////////////////////////////////////////////////////////////
    // Audio
    ////////////////////////////////////////////////////////////////////////
    aq_audio_mixer i_aq_audio_mixer (
        .clk   (clk),
        .reset (reset),
        .pcm   (pcm),
        .fm    (fm),
        .mix   (mix)
    );

endmodule

`default_nettype wire

// File: design/aq_machine_timer.sv
`default_nettype none

`include "aq_cfg.svh"

module aq_machine_timer import aq_bus_pkg::*, aq_periph_pkg::*; #(
    parameter int tick_div = `AQ_TICK_DIV_DEFAULT
) (
    input  wire            clk,
    input  wire            reset,
    input  wire reg_wen_t  wen,
    input  wire bus_data_t wrdata,
    output mtime_t         mtime,
    output mtime_t         mtimecmp,
    output logic           timer_irq
);

    localparam int cnt_w = $clog2(tick_div);

    typedef logic [cnt_w-1:0] tick_cnt_t;

    tick_cnt_t tick_cnt;
    logic      tick;

    ////////////////////////////////////////////////////////////////////////
    // Millisecond tick
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (tick_cnt == tick_cnt_t'(tick_div - 1)) begin
                tick_cnt <= '0;
                tick     <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt + tick_cnt_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Count, compare and interrupt
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtime     <= '0;
            mtimecmp  <= '0;
            timer_irq <= 1'b0;
        end else begin
            if (tick)
                mtime <= mtime + mtime_t'(1);

            // Later assignments override the increment for the written half
            if (wen.mtime)     mtime[31:0]     <= wrdata;
            if (wen.mtimeh)    mtime[63:32]    <= wrdata;
            if (wen.mtimecmp)  mtimecmp[31:0]  <= wrdata;
            if (wen.mtimecmph) mtimecmp[63:32] <= wrdata;

            timer_irq <= (mtimecmp <= mtime);
        end
    end

    // A divider of one would hold the tick high forever
    a_tick_div_range: assert property (@(posedge clk) tick_div > 1)
        else $error("aq_machine_timer: tick_div must be greater than 1");

    a_tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("aq_machine_timer: tick held for two cycles");

endmodule

`default_nettype wire

// File: design/aq_periph_pkg.sv
`default_nettype none

`include "aq_cfg.svh"

package aq_periph_pkg;

    typedef logic [`AQ_SCRX_W-1:0] scrx_t;
    typedef logic [`AQ_SCRY_W-1:0] scry_t;
    typedef logic [8:0]            line_t;

    // Bit 6 down to bit 0 as seen on the bus
    typedef struct packed {
        logic layer2_enable;
        logic sprites_enable;
        logic gfx_tilemode;
        logic gfx_enable;
        logic text_priority;
        logic text_mode80;
        logic text_enable;
    } vctrl_t;

    typedef struct packed {
        vctrl_t vctrl;
        scrx_t  l1_scrx;
        scry_t  l1_scry;
        scrx_t  l2_scrx;
        scry_t  l2_scry;
        line_t  irqline;
    } video_regs_t;

    // Audio
    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef logic [63:0] mtime_t;

endpackage

`default_nettype wire

// File: design/aq_video_regs.sv
`default_nettype none

module aq_video_regs import aq_bus_pkg::*, aq_periph_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire reg_wen_t  wen,
    input  wire bus_data_t wrdata,
    output video_regs_t    regs
);

    ////////////////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////////////////

    // Each register keeps only its low bits of the bus word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '0;
        end else begin
            if (wen.vctrl)
                regs.vctrl <= vctrl_t'(wrdata[$bits(vctrl_t)-1:0]);

            // Layer 1 scroll
            if (wen.l1_scrx)
                regs.l1_scrx <= wrdata[$bits(scrx_t)-1:0];
            if (wen.l1_scry)
                regs.l1_scry <= wrdata[$bits(scry_t)-1:0];

            // Layer 2 scroll
            if (wen.l2_scrx)
                regs.l2_scrx <= wrdata[$bits(scrx_t)-1:0];
            if (wen.l2_scry)
                regs.l2_scry <= wrdata[$bits(scry_t)-1:0];

            // raster line that raises the line interrupt
            if (wen.virqline)
                regs.irqline <= wrdata[$bits(line_t)-1:0];
        end
    end

endmodule

`default_nettype wire

// File: include/aq_cfg.svh
`ifndef AQ_CFG_SVH
`define AQ_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

// Video control block
`define AQ_ADDR_VCTRL       32'h0000_2040
`define AQ_ADDR_VIRQLINE    32'h0000_204C
`define AQ_ADDR_L1_SCRX     32'h0000_2050
`define AQ_ADDR_L1_SCRY     32'h0000_2054
`define AQ_ADDR_L2_SCRX     32'h0000_2058
`define AQ_ADDR_L2_SCRY     32'h0000_205C

// Machine timer, low word first
`define AQ_ADDR_MTIME       32'h0000_2080
`define AQ_ADDR_MTIMEH      32'h0000_2084
`define AQ_ADDR_MTIMECMP    32'h0000_2088
`define AQ_ADDR_MTIMECMPH   32'h0000_208C

////////////////////////////////////////////////////////////////////////////
// Timing and field widths
////////////////////////////////////////////////////////////////////////////

// Clock cycles per 1 ms tick at 25.175 MHz
`define AQ_TICK_DIV_DEFAULT 25175

// Scroll position widths
`define AQ_SCRX_W           9
`define AQ_SCRY_W           8

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a failing run exits non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_aq_io_top -f build.f -o sim_tb

./obj_dir/sim_tb

// File: test/tb_aq_io_top.sv
`default_nettype none

`include "aq_cfg.svh"

module tb_aq_io_top import aq_bus_pkg::*, aq_periph_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_READ_RANGE, OP_WAIT, OP_IRQ, OP_VREGS
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [63:0] expected;
    } entry_t;

    // All six video fields at their full width, 50 bits
    localparam logic [63:0] vregs_all_ones = 64'h0003_FFFF_FFFF_FFFF;
    localparam int          mixer_pairs    = 200;

    logic        clk;
    logic        reset;
    bus_req_t    bus;
    bus_data_t   rddata;
    stereo_t     pcm;
    stereo_t     fm;
    stereo_t     mix;
    video_regs_t video_regs;
    logic        timer_irq;

    entry_t      steps [$];
    string       names [$];
    int unsigned table_cycles;
    int unsigned cycles;
    int unsigned limit;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    aq_io_top #(
        .tick_div (8)
    ) i_aq_io_top (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .rddata     (rddata),
        .pcm        (pcm),
        .fm         (fm),
        .mix        (mix),
        .video_regs (video_regs),
        .timer_irq  (timer_irq)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_step(input string name, input op_t op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [63:0] expected);
        steps.push_back('{op: op, addr: addr, data: data, expected: expected});
        names.push_back(name);
        table_cycles += (op == OP_WAIT) ? data : 1;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Signed sum clamped to the 16-bit range
    function automatic sample_t clamp_sum(input sample_t a, input sample_t b);
        int total;
        total = int'(a) + int'(b);
        if (total > 32767)
            total = 32767;
        else if (total < -32768)
            total = -32768;
        return sample_t'(total);
    endfunction

    task automatic run_step(input entry_t e, input string name);
        logic [63:0] lower;
        @(negedge clk);
        bus = '0;
        case (e.op)
            OP_WRITE: begin
                bus = '{strobe: 1'b1, wren: 1'b1, addr: e.addr, wrdata: e.data,
                        bytesel: 4'hF};
            end
            OP_READ, OP_READ_RANGE: begin
                bus = '{strobe: 1'b1, wren: 1'b0, addr: e.addr, wrdata: '0,
                        bytesel: 4'hF};
                #10;
                lower = e.expected;
                // Range reads accept one extra tick
                if (e.op == OP_READ_RANGE && 64'(rddata) == e.expected + 64'd1)
                    lower = e.expected + 64'd1;
                check_value(name, lower, 64'(rddata));
            end
            OP_WAIT: repeat (e.data - 1) @(negedge clk);
            OP_IRQ: begin
                #10;
                check_value(name, e.expected, 64'(timer_irq));
            end
            default: check_value(name, e.expected, 64'(video_regs));
        endcase
    endtask

    task automatic run_mixer();
        logic [31:0] seed;
        stereo_t     expected;
        seed = 32'hec3a;
        expected = '0;
        for (int i = 0; i <= mixer_pairs; i++) begin
            @(negedge clk);
            if (i > 0)
                check_value($sformatf("mixer_%0d", i - 1), 64'(expected), 64'(mix));
            if (i == 0) begin
                pcm = '{left: 16'h7FFF, right: 16'h8000};
                fm  = '{left: 16'h7FFF, right: 16'h8000};
            end else if (i == 1) begin
                pcm = '{left: 16'h8000, right: 16'h7FFF};
                fm  = '{left: 16'h8000, right: 16'h7FFF};
            end else if (i < mixer_pairs) begin
                seed = lcg_next(seed);
                pcm.left = seed[31:16];
                seed = lcg_next(seed);
                pcm.right = seed[31:16];
                seed = lcg_next(seed);
                fm.left = seed[31:16];
                seed = lcg_next(seed);
                fm.right = seed[31:16];
            end
            expected.left  = clamp_sum(pcm.left, fm.left);
            expected.right = clamp_sum(pcm.right, fm.right);
        end
    endtask

    task automatic build_table();
        // Reset values, mtime low first while no tick has landed yet
        add_step("irq_after_rst", OP_IRQ, 32'h0, 32'h0, 64'h1);
        add_step("mtime_rst", OP_READ, `AQ_ADDR_MTIME, 32'h0, 64'h0);
        add_step("mtimeh_rst", OP_READ, `AQ_ADDR_MTIMEH, 32'h0, 64'h0);
        add_step("mtimecmp_rst", OP_READ, `AQ_ADDR_MTIMECMP, 32'h0, 64'h0);
        add_step("mtimecmph_rst", OP_READ, `AQ_ADDR_MTIMECMPH, 32'h0, 64'h0);
        add_step("vctrl_rst", OP_READ, `AQ_ADDR_VCTRL, 32'h0, 64'h0);
        add_step("virqline_rst", OP_READ, `AQ_ADDR_VIRQLINE, 32'h0, 64'h0);
        add_step("l1_scrx_rst", OP_READ, `AQ_ADDR_L1_SCRX, 32'h0, 64'h0);
        add_step("l1_scry_rst", OP_READ, `AQ_ADDR_L1_SCRY, 32'h0, 64'h0);
        add_step("l2_scrx_rst", OP_READ, `AQ_ADDR_L2_SCRX, 32'h0, 64'h0);
        add_step("l2_scry_rst", OP_READ, `AQ_ADDR_L2_SCRY, 32'h0, 64'h0);

        // Video registers keep only their field width
        add_step("vctrl_wr", OP_WRITE, `AQ_ADDR_VCTRL, 32'hFFFF_FFFF, 64'h0);
        add_step("virqline_wr", OP_WRITE, `AQ_ADDR_VIRQLINE, 32'hFFFF_FFFF, 64'h0);
        add_step("l1_scrx_wr", OP_WRITE, `AQ_ADDR_L1_SCRX, 32'hFFFF_FFFF, 64'h0);
        add_step("l1_scry_wr", OP_WRITE, `AQ_ADDR_L1_SCRY, 32'hFFFF_FFFF, 64'h0);
        add_step("l2_scrx_wr", OP_WRITE, `AQ_ADDR_L2_SCRX, 32'hFFFF_FFFF, 64'h0);
        add_step("l2_scry_wr", OP_WRITE, `AQ_ADDR_L2_SCRY, 32'hFFFF_FFFF, 64'h0);
        add_step("vctrl_rd", OP_READ, `AQ_ADDR_VCTRL, 32'h0, 64'h7F);
        add_step("virqline_rd", OP_READ, `AQ_ADDR_VIRQLINE, 32'h0, 64'h1FF);
        add_step("l1_scrx_rd", OP_READ, `AQ_ADDR_L1_SCRX, 32'h0, 64'h1FF);
        add_step("l1_scry_rd", OP_READ, `AQ_ADDR_L1_SCRY, 32'h0, 64'hFF);
        add_step("l2_scrx_rd", OP_READ, `AQ_ADDR_L2_SCRX, 32'h0, 64'h1FF);
        add_step("l2_scry_rd", OP_READ, `AQ_ADDR_L2_SCRY, 32'h0, 64'hFF);
        add_step("video_out", OP_VREGS, 32'h0, 32'h0, vregs_all_ones);

        // Unmapped word with every video field set
        add_step("unmapped", OP_READ, 32'h0000_2060, 32'h0, 64'h0);

        // 40 cycles at tick_div 8 add five ticks, six at most
        add_step("mtimeh_wr", OP_WRITE, `AQ_ADDR_MTIMEH, 32'h0000_0012, 64'h0);
        add_step("mtime_wr", OP_WRITE, `AQ_ADDR_MTIME, 32'h1000_0000, 64'h0);
        add_step("mtime_wait", OP_WAIT, 32'h0, 32'd40, 64'h0);
        add_step("mtime_count", OP_READ_RANGE, `AQ_ADDR_MTIME, 32'h0, 64'h1000_0005);
        add_step("mtimeh_rd", OP_READ, `AQ_ADDR_MTIMEH, 32'h0, 64'h12);

        // Compare interrupt
        add_step("cmph_wr", OP_WRITE, `AQ_ADDR_MTIMECMPH, 32'hFFFF_FFFF, 64'h0);
        add_step("cmph_wait", OP_WAIT, 32'h0, 32'd1, 64'h0);
        add_step("irq_low", OP_IRQ, 32'h0, 32'h0, 64'h0);
        add_step("mtimeh_max_wr", OP_WRITE, `AQ_ADDR_MTIMEH, 32'hFFFF_FFFF, 64'h0);
        add_step("mtimeh_wait", OP_WAIT, 32'h0, 32'd1, 64'h0);
        add_step("irq_high", OP_IRQ, 32'h0, 32'h0, 64'h1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        bus = '0;
        pcm = '0;
        fm = '0;
        cycles = 0;
        table_cycles = 0;
        build_table();
        limit = 2 * (table_cycles + mixer_pairs + 1) + 200;
        @(negedge reset);
        foreach (steps[i])
            run_step(steps[i], names[i]);
        @(negedge clk);
        bus = '0;
        run_mixer();
        $display("*** TEST PASSED ***");
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the sequence did not complete", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Held over four rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire
